//--- common/soc_pkg.sv
package soc_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 16;
  localparam int SEL_W  = 4;
  localparam int REG_W  = 12;
  localparam int EXC_W  = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [SEL_W-1:0]  sel_t;
  typedef logic [REG_W-1:0]  reg_t;
  typedef logic [EXC_W-1:0]  excode_t;

  // peripheral select codes, taken from adr[15:12]
  localparam sel_t SEL_GPIO  = 4'd0;
  localparam sel_t SEL_TIMER = 4'd8;

  // gpio register map
  localparam reg_t GPIO_LED = 12'd0;
  localparam reg_t GPIO_SW  = 12'd1;

  // timer register map, compare channel n sits at TMR_CMP0 + n
  localparam reg_t TMR_CTRL   = 12'd0;
  localparam reg_t TMR_COUNT  = 12'd1;
  localparam reg_t TMR_STATUS = 12'd2;
  localparam reg_t TMR_CMP0   = 12'd4;

  // exception codes seen by the cpu, timer channel n gives EXC_TIMER0 + n
  localparam excode_t EXC_NONE   = 4'd0;
  localparam excode_t EXC_BUSERR = 4'd1;
  localparam excode_t EXC_TIMER0 = 4'd2;

endpackage

//--- list.f
common/soc_pkg.sv
logic/io_decoder.sv
logic/gpio_regs.sv
timer/timer_regs.sv
timer/timer_core.sv
logic/int_encoder.sv
logic/io_top.sv
tests/io_top_tb.sv

//--- logic/gpio_regs.sv
`timescale 1ns/10ps

module gpio_regs #(
  parameter int LED_W = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             wr_i,
  input  logic             rd_i,
  input  soc_pkg::reg_t    reg_i,
  input  soc_pkg::data_t   wdat_i,
  output soc_pkg::data_t   rdat_o,
  input  logic [1:0]       sw_i,
  output logic [LED_W-1:0] led_o
);

  logic [1:0] sw_meta;
  logic [1:0] sw_sync;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_o   <= '0;
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      // switches are asynchronous to the system clock
      sw_meta <= sw_i;
      sw_sync <= sw_meta;
      if (wr_i && reg_i == soc_pkg::GPIO_LED) begin
        led_o <= wdat_i[LED_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      case (reg_i)
        soc_pkg::GPIO_LED: rdat_o <= soc_pkg::data_t'(led_o);
        soc_pkg::GPIO_SW:  rdat_o <= soc_pkg::data_t'(sw_sync);
        default:           rdat_o <= '0;
      endcase
    end
  end

endmodule

//--- logic/int_encoder.sv
`timescale 1ns/10ps

module int_encoder #(
  parameter int TIMER_CH = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                bus_err_i,
  input  logic [TIMER_CH-1:0] tmr_int_i,
  input  logic                int_en_i,
  input  logic                int_clr_i,
  output soc_pkg::excode_t    exc_o
);

  logic             err_flag;
  logic             err_nxt;
  soc_pkg::excode_t exc_nxt;

  // clear has priority so software can always drop the flag
  assign err_nxt = int_clr_i ? 1'b0 : (err_flag | bus_err_i);

  always_comb begin
    exc_nxt = soc_pkg::EXC_NONE;
    // walk down so channel 0 ends up with the highest timer priority
    for (int i = TIMER_CH - 1; i >= 0; i--) begin
      if (tmr_int_i[i]) begin
        exc_nxt = soc_pkg::EXC_TIMER0 + soc_pkg::excode_t'(i);
      end
    end
    if (err_nxt) begin
      exc_nxt = soc_pkg::EXC_BUSERR;
    end
    if (!int_en_i) begin
      exc_nxt = soc_pkg::EXC_NONE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_flag <= 1'b0;
      exc_o    <= soc_pkg::EXC_NONE;
    end else begin
      err_flag <= err_nxt;
      exc_o    <= exc_nxt;
    end
  end

endmodule

//--- logic/io_decoder.sv
`timescale 1ns/10ps

module io_decoder (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           cyc_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::addr_t adr_i,
  output logic           ack_o,
  output logic           err_o,
  output logic           gpio_wr_o,
  output logic           gpio_rd_o,
  output logic           tmr_wr_o,
  output logic           tmr_rd_o,
  input  soc_pkg::data_t gpio_rdat_i,
  input  soc_pkg::data_t tmr_rdat_i,
  output soc_pkg::data_t rdat_o,
  output logic           bus_err_o
);

  soc_pkg::sel_t sel;
  soc_pkg::sel_t sel_q;
  logic          req;
  logic          gpio_hit;
  logic          tmr_hit;

  // a new access is seen once, in the cycle before ack
  assign req      = cyc_i & stb_i & ~ack_o;
  assign sel      = adr_i[15:12];
  assign gpio_hit = (sel == soc_pkg::SEL_GPIO);
  assign tmr_hit  = (sel == soc_pkg::SEL_TIMER);

  // reads are strobed early so the peripheral data lines up with ack
  assign gpio_rd_o = req & ~we_i & gpio_hit;
  assign tmr_rd_o  = req & ~we_i & tmr_hit;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o     <= 1'b0;
      err_o     <= 1'b0;
      sel_q     <= '0;
      gpio_wr_o <= 1'b0;
      tmr_wr_o  <= 1'b0;
    end else begin
      ack_o     <= req;
      err_o     <= req & ~gpio_hit & ~tmr_hit;
      gpio_wr_o <= req & we_i & gpio_hit;
      tmr_wr_o  <= req & we_i & tmr_hit;
      if (req) begin
        sel_q <= sel;
      end
    end
  end

  always_comb begin
    case (sel_q)
      soc_pkg::SEL_GPIO:  rdat_o = gpio_rdat_i;
      soc_pkg::SEL_TIMER: rdat_o = tmr_rdat_i;
      default:            rdat_o = '0;
    endcase
  end

  // the error ack doubles as the exception source
  assign bus_err_o = err_o;

endmodule

//--- logic/io_top.sv
`timescale 1ns/10ps

module io_top #(
  parameter int TIMER_CH = 4,
  parameter int LED_W    = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             cyc_i,
  input  logic             stb_i,
  input  logic             we_i,
  input  soc_pkg::addr_t   adr_i,
  input  soc_pkg::data_t   wdat_i,
  output logic             ack_o,
  output soc_pkg::data_t   rdat_o,
  output logic             err_o,
  input  logic [1:0]       sw_i,
  output logic [LED_W-1:0] led_o,
  input  logic             int_en_i,
  input  logic             int_clr_i,
  output soc_pkg::excode_t exc_o
);

  logic                          gpio_wr;
  logic                          gpio_rd;
  logic                          tmr_wr;
  logic                          tmr_rd;
  logic                          bus_err;
  soc_pkg::data_t                gpio_rdat;
  soc_pkg::data_t                tmr_rdat;
  soc_pkg::data_t                count;
  logic [TIMER_CH-1:0]           pend;
  logic                          run;
  logic [TIMER_CH-1:0]           ch_en;
  soc_pkg::data_t [TIMER_CH-1:0] cmp;
  logic                          load;
  soc_pkg::data_t                load_val;
  logic [TIMER_CH-1:0]           clr;

  io_decoder u_io_decoder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .adr_i       (adr_i),
    .ack_o       (ack_o),
    .err_o       (err_o),
    .gpio_wr_o   (gpio_wr),
    .gpio_rd_o   (gpio_rd),
    .tmr_wr_o    (tmr_wr),
    .tmr_rd_o    (tmr_rd),
    .gpio_rdat_i (gpio_rdat),
    .tmr_rdat_i  (tmr_rdat),
    .rdat_o      (rdat_o),
    .bus_err_o   (bus_err)
  );

  gpio_regs #(.LED_W(LED_W)) u_gpio_regs (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wr_i    (gpio_wr),
    .rd_i    (gpio_rd),
    .reg_i   (adr_i[11:0]),
    .wdat_i  (wdat_i),
    .rdat_o  (gpio_rdat),
    .sw_i    (sw_i),
    .led_o   (led_o)
  );

  timer_regs #(.TIMER_CH(TIMER_CH)) u_timer_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_i       (tmr_wr),
    .rd_i       (tmr_rd),
    .reg_i      (adr_i[11:0]),
    .wdat_i     (wdat_i),
    .rdat_o     (tmr_rdat),
    .count_i    (count),
    .pend_i     (pend),
    .run_o      (run),
    .ch_en_o    (ch_en),
    .cmp_o      (cmp),
    .load_o     (load),
    .load_val_o (load_val),
    .clr_o      (clr)
  );

  timer_core #(.TIMER_CH(TIMER_CH)) u_timer_core (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .run_i      (run),
    .ch_en_i    (ch_en),
    .cmp_i      (cmp),
    .load_i     (load),
    .load_val_i (load_val),
    .clr_i      (clr),
    .count_o    (count),
    .pend_o     (pend)
  );

  int_encoder #(.TIMER_CH(TIMER_CH)) u_int_encoder (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .bus_err_i (bus_err),
    .tmr_int_i (pend),
    .int_en_i  (int_en_i),
    .int_clr_i (int_clr_i),
    .exc_o     (exc_o)
  );

endmodule

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f list.f --top-module io_top_tb \
    -Mdir obj_dir -o io_top_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/io_top_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tests/io_top_tb.sv
`timescale 1ns/10ps

module io_top_tb;

  localparam int TIMER_CH = 4;
  localparam int LED_W    = 8;
  localparam int N_GPIO   = 16;
  localparam int N_TMR    = 16;
  localparam int N_IRQ    = 8;
  localparam int N_ERR    = 8;
  // every access spends three edges on the bus
  localparam int N_ACC    = 3 * N_GPIO + TIMER_CH + 3 * N_TMR + N_IRQ * (5 + TIMER_CH) + N_ERR;
  localparam int CYCLE_LIMIT = 2 * N_ACC * 4 + 1000;

  logic             clk;
  logic             rst_n_i;
  logic             cyc_i;
  logic             stb_i;
  logic             we_i;
  soc_pkg::addr_t   adr_i;
  soc_pkg::data_t   wdat_i;
  logic             ack_o;
  soc_pkg::data_t   rdat_o;
  logic             err_o;
  logic [1:0]       sw_i;
  logic [LED_W-1:0] led_o;
  logic             int_en_i;
  logic             int_clr_i;
  soc_pkg::excode_t exc_o;

  // register-level model of the peripherals
  logic [LED_W-1:0]    m_led;
  logic [1:0]          m_sw;
  logic                m_run;
  logic [TIMER_CH-1:0] m_ch_en;
  logic [TIMER_CH-1:0] m_pend;
  soc_pkg::data_t      m_count;
  soc_pkg::data_t      m_cmp [TIMER_CH];
  soc_pkg::data_t      m_rdat;
  logic                m_err;
  soc_pkg::excode_t    m_exc;

  logic [31:0] rng;
  int          cycles = 0;

  io_top #(.TIMER_CH(TIMER_CH), .LED_W(LED_W)) u_io_top (
    .clk_i     (clk),
    .rst_n_i   (rst_n_i),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .we_i      (we_i),
    .adr_i     (adr_i),
    .wdat_i    (wdat_i),
    .ack_o     (ack_o),
    .rdat_o    (rdat_o),
    .err_o     (err_o),
    .sw_i      (sw_i),
    .led_o     (led_o),
    .int_en_i  (int_en_i),
    .int_clr_i (int_clr_i),
    .exc_o     (exc_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic is_unmapped(input soc_pkg::sel_t sel);
    return (sel != soc_pkg::SEL_GPIO) && (sel != soc_pkg::SEL_TIMER);
  endfunction

  function automatic soc_pkg::data_t model_read(input soc_pkg::addr_t adr);
    soc_pkg::data_t val;
    soc_pkg::sel_t  sel;
    soc_pkg::reg_t  offs;
    val  = '0;
    sel  = adr[15:12];
    offs = adr[11:0];
    if (sel == soc_pkg::SEL_GPIO) begin
      if (offs == soc_pkg::GPIO_LED) val[LED_W-1:0] = m_led;
      else if (offs == soc_pkg::GPIO_SW) val[1:0] = m_sw;
    end else if (sel == soc_pkg::SEL_TIMER) begin
      if (offs == soc_pkg::TMR_CTRL) begin
        val[0]             = m_run;
        val[8 +: TIMER_CH] = m_ch_en;
      end else if (offs == soc_pkg::TMR_COUNT) begin
        val = m_count;
      end else if (offs == soc_pkg::TMR_STATUS) begin
        val[TIMER_CH-1:0] = m_pend;
      end else if (offs >= soc_pkg::TMR_CMP0 && offs < soc_pkg::TMR_CMP0 + TIMER_CH) begin
        val = m_cmp[offs - soc_pkg::TMR_CMP0];
      end
    end
    return val;
  endfunction

  // phase 1 ends the request cycle, phase 2 ends the ack cycle
  task automatic model_update(input int phase);
    logic [TIMER_CH-1:0] hit;
    logic [TIMER_CH-1:0] clr;
    logic                err_nxt;
    logic                tmr_wr;
    soc_pkg::reg_t       offs;
    offs   = adr_i[11:0];
    tmr_wr = (phase == 2) && we_i && (adr_i[15:12] == soc_pkg::SEL_TIMER);
    if (phase == 1) m_rdat = model_read(adr_i);
    err_nxt = (m_err || (phase == 2 && is_unmapped(adr_i[15:12]))) && !int_clr_i;
    m_exc = soc_pkg::EXC_NONE;
    if (int_en_i && err_nxt) begin
      m_exc = soc_pkg::EXC_BUSERR;
    end else if (int_en_i) begin
      for (int i = 0; i < TIMER_CH; i++) begin
        if (m_pend[i] && m_exc == soc_pkg::EXC_NONE) m_exc = soc_pkg::EXC_TIMER0 + 4'(i);
      end
    end
    m_err = err_nxt;
    for (int i = 0; i < TIMER_CH; i++) begin
      hit[i] = m_ch_en[i] && (m_count == m_cmp[i]);
    end
    clr = (tmr_wr && offs == soc_pkg::TMR_STATUS) ? wdat_i[TIMER_CH-1:0] : '0;
    m_pend = (m_pend | hit) & ~clr;
    if (tmr_wr && offs == soc_pkg::TMR_COUNT) m_count = wdat_i;
    else if (m_run) m_count = m_count + 32'd1;
    if (tmr_wr && offs == soc_pkg::TMR_CTRL) begin
      m_run   = wdat_i[0];
      m_ch_en = wdat_i[8 +: TIMER_CH];
    end
    if (tmr_wr && offs >= soc_pkg::TMR_CMP0 && offs < soc_pkg::TMR_CMP0 + TIMER_CH) begin
      m_cmp[offs - soc_pkg::TMR_CMP0] = wdat_i;
    end
    if (phase == 2 && we_i && adr_i[15:12] == soc_pkg::SEL_GPIO && offs == soc_pkg::GPIO_LED) begin
      m_led = wdat_i[LED_W-1:0];
    end
  endtask

  task automatic edge_step(input int phase);
    @(posedge clk);
    model_update(phase);
  endtask

  task automatic sample_outputs();
    @(negedge clk);
    check_value("exc_o", 32'(m_exc), 32'(exc_o));
    check_value("led_o", 32'(m_led), 32'(led_o));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      edge_step(0);
      sample_outputs();
    end
  endtask

  task automatic drive_int(input logic en, input logic clr);
    edge_step(0);
    int_en_i  <= en;
    int_clr_i <= clr;
    sample_outputs();
  endtask

  task automatic bus_access(input logic we, input soc_pkg::addr_t adr,
                            input soc_pkg::data_t wdat, input string name);
    int   lat;
    logic exp_err;
    exp_err = is_unmapped(adr[15:12]);
    edge_step(0);
    cyc_i  <= 1'b1;
    stb_i  <= 1'b1;
    we_i   <= we;
    adr_i  <= adr;
    wdat_i <= wdat;
    sample_outputs();
    check_value({name, " early ack"}, 0, 32'(ack_o));
    lat = 0;
    do begin
      edge_step(lat == 0 ? 1 : 0);
      sample_outputs();
      lat++;
    end while (!ack_o && lat < 8);
    check_value({name, " ack latency"}, 1, lat);
    check_value({name, " err"}, 32'(exp_err), 32'(err_o));
    if (!we) check_value({name, " read data"}, m_rdat, rdat_o);
    edge_step(2);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    sample_outputs();
    check_value({name, " ack width"}, 0, 32'(ack_o));
    check_value({name, " err width"}, 0, 32'(err_o));
  endtask

  initial begin
    logic [3:0] sel;
    rst_n_i   = 1'b0;
    cyc_i     = 1'b0;
    stb_i     = 1'b0;
    we_i      = 1'b0;
    adr_i     = '0;
    wdat_i    = '0;
    sw_i      = 2'b00;
    int_en_i  = 1'b0;
    int_clr_i = 1'b0;
    rng       = 32'd36;
    m_led     = '0;
    m_sw      = '0;
    m_run     = 1'b0;
    m_ch_en   = '0;
    m_pend    = '0;
    m_count   = '0;
    m_rdat    = '0;
    m_err     = 1'b0;
    m_exc     = soc_pkg::EXC_NONE;
    for (int i = 0; i < TIMER_CH; i++) m_cmp[i] = '0;

    repeat (8) @(posedge clk);
    rst_n_i <= 1'b1;
    sample_outputs();
    check_value("reset ack", 0, 32'(ack_o));
    check_value("reset err", 0, 32'(err_o));

    for (int n = 0; n < N_GPIO; n++) begin
      bus_access(1'b1, {soc_pkg::SEL_GPIO, soc_pkg::GPIO_LED}, xorshift32(), "led write");
      edge_step(0);
      m_sw = 2'(xorshift32() % 4);
      sw_i <= m_sw;
      sample_outputs();
      // the synchronizer needs a few cycles before the read samples it
      idle(3);
      bus_access(1'b0, {soc_pkg::SEL_GPIO, soc_pkg::GPIO_SW}, '0, "switch read");
      bus_access(1'b0, {soc_pkg::SEL_GPIO, soc_pkg::reg_t'(xorshift32() % 4)}, '0, "gpio read");
    end

    for (int n = 0; n < TIMER_CH; n++) begin
      bus_access(1'b1, {soc_pkg::SEL_TIMER, soc_pkg::TMR_CMP0 + soc_pkg::reg_t'(n)},
                 xorshift32(), "cmp init");
    end
    for (int n = 0; n < N_TMR; n++) begin
      bus_access(1'b1, {soc_pkg::SEL_TIMER, soc_pkg::reg_t'(xorshift32() % 12)},
                 xorshift32(), "timer write");
      bus_access(1'b0, adr_i, '0, "timer readback");
      bus_access(1'b0, {soc_pkg::SEL_TIMER, soc_pkg::reg_t'(xorshift32() % 12)}, '0,
                 "timer read");
    end

    for (int n = 0; n < N_IRQ; n++) begin
      drive_int(xorshift32() % 2 == 1, 1'b0);
      bus_access(1'b1, {soc_pkg::SEL_TIMER, soc_pkg::TMR_COUNT}, xorshift32(), "count load");
      bus_access(1'b1, {soc_pkg::SEL_TIMER, soc_pkg::TMR_CTRL},
                 32'h1 | ((xorshift32() % (1 << TIMER_CH)) << 8), "irq ctrl");
      for (int ch = 0; ch < TIMER_CH; ch++) begin
        bus_access(1'b1, {soc_pkg::SEL_TIMER, soc_pkg::TMR_CMP0 + soc_pkg::reg_t'(ch)},
                   m_count + 32'd20 + xorshift32() % 8, "irq cmp");
      end
      idle(32);
      bus_access(1'b0, {soc_pkg::SEL_TIMER, soc_pkg::TMR_STATUS}, '0, "status read");
      bus_access(1'b1, {soc_pkg::SEL_TIMER, soc_pkg::TMR_STATUS}, xorshift32(), "status clear");
      bus_access(1'b0, {soc_pkg::SEL_TIMER, soc_pkg::TMR_STATUS}, '0, "status after clear");
    end

    drive_int(1'b1, 1'b0);
    for (int n = 0; n < N_ERR; n++) begin
      // selects 1 to 15 with the timer's select skipped
      sel = 4'(xorshift32() % 14 + 1);
      if (sel >= soc_pkg::SEL_TIMER) sel = sel + 4'd1;
      bus_access(xorshift32() % 2 == 1, {sel, soc_pkg::reg_t'(xorshift32())}, xorshift32(),
                 "decode error");
      check_value("sticky bus error", 32'(soc_pkg::EXC_BUSERR), 32'(exc_o));
      drive_int(1'b1, 1'b1);
      drive_int(1'b1, 1'b0);
    end

    drive_int(1'b0, 1'b0);
    idle(2);
    check_value("exc disabled", 32'(soc_pkg::EXC_NONE), 32'(exc_o));

    $display("TEST OK");
    $finish;
  end

endmodule

//--- timer/timer_core.sv
`timescale 1ns/10ps

module timer_core #(
  parameter int TIMER_CH = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          run_i,
  input  logic [TIMER_CH-1:0]           ch_en_i,
  input  soc_pkg::data_t [TIMER_CH-1:0] cmp_i,
  input  logic                          load_i,
  input  soc_pkg::data_t                load_val_i,
  input  logic [TIMER_CH-1:0]           clr_i,
  output soc_pkg::data_t                count_o,
  output logic [TIMER_CH-1:0]           pend_o
);

  logic [TIMER_CH-1:0] hit;

  // a load from the bus wins over counting
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_o <= '0;
    end else if (load_i) begin
      count_o <= load_val_i;
    end else if (run_i) begin
      count_o <= count_o + 1'b1;
    end
  end

  always_comb begin
    for (int i = 0; i < TIMER_CH; i++) begin
      hit[i] = ch_en_i[i] && (count_o == cmp_i[i]);
    end
  end

  // pending bits are sticky until software writes ones to status
  // and a clear beats a match arriving in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_o <= '0;
    end else begin
      pend_o <= (pend_o | hit) & ~clr_i;
    end
  end

endmodule

//--- timer/timer_regs.sv
`timescale 1ns/10ps

module timer_regs #(
  parameter int TIMER_CH = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           wr_i,
  input  logic                           rd_i,
  input  soc_pkg::reg_t                  reg_i,
  input  soc_pkg::data_t                 wdat_i,
  output soc_pkg::data_t                 rdat_o,
  input  soc_pkg::data_t                 count_i,
  input  logic [TIMER_CH-1:0]            pend_i,
  output logic                           run_o,
  output logic [TIMER_CH-1:0]            ch_en_o,
  output soc_pkg::data_t [TIMER_CH-1:0]  cmp_o,
  output logic                           load_o,
  output soc_pkg::data_t                 load_val_o,
  output logic [TIMER_CH-1:0]            clr_o
);

  soc_pkg::data_t ctrl_word;
  soc_pkg::data_t rd_word;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_o   <= 1'b0;
      ch_en_o <= '0;
    end else if (wr_i && reg_i == soc_pkg::TMR_CTRL) begin
      run_o   <= wdat_i[0];
      ch_en_o <= wdat_i[8 +: TIMER_CH];
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      for (int i = 0; i < TIMER_CH; i++) begin
        if (reg_i == soc_pkg::TMR_CMP0 + soc_pkg::reg_t'(i)) begin
          cmp_o[i] <= wdat_i;
        end
      end
    end
  end

  // load and clear act on the core at the same edge as the write
  assign load_o     = wr_i && (reg_i == soc_pkg::TMR_COUNT);
  assign load_val_o = wdat_i;
  assign clr_o      = (wr_i && reg_i == soc_pkg::TMR_STATUS) ? wdat_i[TIMER_CH-1:0] : '0;

  always_comb begin
    ctrl_word                 = '0;
    ctrl_word[0]              = run_o;
    ctrl_word[8 +: TIMER_CH]  = ch_en_o;
  end

  always_comb begin
    case (reg_i)
      soc_pkg::TMR_CTRL:   rd_word = ctrl_word;
      soc_pkg::TMR_COUNT:  rd_word = count_i;
      soc_pkg::TMR_STATUS: rd_word = soc_pkg::data_t'(pend_i);
      default:             rd_word = '0;
    endcase
    for (int i = 0; i < TIMER_CH; i++) begin
      if (reg_i == soc_pkg::TMR_CMP0 + soc_pkg::reg_t'(i)) begin
        rd_word = cmp_o[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rdat_o <= rd_word;
    end
  end

endmodule
